/* UsiSystem.f */
logic/UsiPkg.sv
logic/UsiCmdReceiver.sv
logic/UsiCmdFifo.sv
logic/GpioBlock.sv
logic/RamBlock.sv
logic/UsiBus.sv
logic/UsiSystem.sv
verif/UsiSystemTb.sv

/* build.sh */
#!/bin/bash
# Compile the testbench with Verilator and run it, failing on a nonzero exit
cd "$(dirname "$0")" && \
verilator --binary -Wno-fatal -f UsiSystem.f --top-module UsiSystemTb -o UsiSystemSim && \
./obj_dir/UsiSystemSim || exit 1

/* verif/UsiSystemTb.sv */
// Random-stimulus testbench for the register bus system with reference model, checks and timeout
`timescale 1ns/1ps

module UsiSystemTb;

	localparam int lpNumCmds = 400;
	// Worst case per command with a full buffer and a slow reader
	localparam int lpCyclesPerCmd = 50;
	localparam int lpMaxCycles = lpNumCmds * lpCyclesPerCmd;
	localparam int unsigned lpSeed = 32'hec540bd7;

	logic sysClk;
	logic rstN;
	UsiPkg::usiCmdT cmd;
	logic cmdReq;
	logic cmdAck;
	UsiPkg::usiRspT rsp;
	logic rspReady;
	logic [1:0] led;
	logic ledB;
	logic ledG;
	logic ledR;

	// Reference model
	logic [4:0] ledModel;
	logic [31:0] scratchModel;
	logic [31:0] ramModel [16];
	logic [31:0] expQueue [$];

	int cycleCount;
	int readsIssued;
	int rspAccepted;
	logic draining;
	logic holdPending;
	logic [31:0] heldRd;
	logic prevAck;
	logic reqAtEdge;

	UsiSystem DUT (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.cmd      (cmd),
		.cmdReq   (cmdReq),
		.cmdAck   (cmdAck),
		.rsp      (rsp),
		.rspReady (rspReady),
		.led      (led),
		.ledB     (ledB),
		.ledG     (ledG),
		.ledR     (ledR)
	);

	always #50 sysClk = ~sysClk;

	// ------------------------------------------------------------------------
	// Error handling
	// ------------------------------------------------------------------------
	task automatic abortRun();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
			abortRun();
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic logic [31:0] modelRead(input logic [3:0] blk, input logic [15:0] csr);
		logic [31:0] value;
		value = '0;
		if (blk == UsiPkg::lpGpioAdrsMap)
		begin
			if (csr[7:0] == UsiPkg::lpGpioLedCsr)
				value = {27'd0, ledModel};
			else if (csr[7:0] == UsiPkg::lpGpioScratchCsr)
				value = scratchModel;
		end
		else if (blk == UsiPkg::lpRamAdrsMap)
		begin
			value = ramModel[csr[5:2]];
		end
		return value;
	endfunction

	// Called once per acked command, so the model follows command order
	task automatic applyCmd(input UsiPkg::usiCmdT c);
		logic [3:0] blk;
		logic [15:0] csr;
		blk = c.adrs[19:16];
		csr = c.adrs[15:0];
		if (c.op == UsiPkg::opRead)
		begin
			expQueue.push_back(modelRead(blk, csr));
			readsIssued++;
		end
		else if (blk == UsiPkg::lpGpioAdrsMap)
		begin
			if (csr[7:0] == UsiPkg::lpGpioLedCsr)
				ledModel = c.wd[4:0];
			else if (csr[7:0] == UsiPkg::lpGpioScratchCsr)
				scratchModel = c.wd;
		end
		else if (blk == UsiPkg::lpRamAdrsMap)
		begin
			ramModel[csr[5:2]] = c.wd;
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	function automatic UsiPkg::usiCmdT randomCmd();
		UsiPkg::usiCmdT c;
		logic [3:0] blk;
		logic [15:0] csr;
		if ($urandom % 10 < 8)
		begin
			if ($urandom % 2 == 0)
			begin
				blk = UsiPkg::lpGpioAdrsMap;
				// LED, scratch, two unused CSRs and a scratch alias
				case ($urandom % 5)
					0: csr = 16'h0000;
					1: csr = 16'h0004;
					2: csr = 16'h0008;
					3: csr = 16'h0010;
					default: csr = 16'h0104;
				endcase
			end
			else
			begin
				blk = UsiPkg::lpRamAdrsMap;
				csr = 16'($urandom) & 16'h013c;
			end
		end
		else
		begin
			blk = 4'($urandom);
			while (blk == UsiPkg::lpGpioAdrsMap || blk == UsiPkg::lpRamAdrsMap)
				blk = 4'($urandom);
			csr = 16'($urandom) & 16'h00fc;
		end
		c.op = ($urandom % 2 == 0) ? UsiPkg::opWrite : UsiPkg::opRead;
		c.adrs = {12'h000, blk, csr};
		c.wd = $urandom;
		return c;
	endfunction

	// Four-phase handshake, entered and left on a falling edge
	task automatic sendCmd(input UsiPkg::usiCmdT c);
		cmd = c;
		cmdReq = 1'b1;
		@(negedge sysClk);
		while (!cmdAck)
			@(negedge sysClk);
		applyCmd(c);
		cmdReq = 1'b0;
		@(negedge sysClk);
		while (cmdAck)
			@(negedge sysClk);
	endtask

	// ------------------------------------------------------------------------
	// Monitors
	// ------------------------------------------------------------------------
	always @(posedge sysClk)
	begin
		reqAtEdge <= cmdReq;
		cycleCount++;
		if (cycleCount >= lpMaxCycles)
		begin
			$display("Timeout: run did not finish within %0d cycles", lpMaxCycles);
			abortRun();
		end
	end

	// Ack may rise only on an edge with req high, and fall only on one with req low
	always @(negedge sysClk)
	begin
		if (rstN)
		begin
			if (cmdAck && !prevAck)
				checkValue("cmdReq at cmdAck rise", 32'(reqAtEdge), 32'd1);
			if (!cmdAck && prevAck)
				checkValue("cmdReq at cmdAck fall", 32'(reqAtEdge), 32'd0);
		end
		prevAck = cmdAck;
	end

	// Reader with random back-pressure
	always @(negedge sysClk)
	begin
		if (rstN)
		begin
			if (holdPending)
			begin
				checkValue("rsp.valid under back-pressure", 32'(rsp.valid), 32'd1);
				checkValue("rsp.rd under back-pressure", rsp.rd, heldRd);
			end
			holdPending = 1'b0;
			rspReady = draining ? 1'b1 : ($urandom % 2 == 0);
			if (rsp.valid && rspReady)
			begin
				// Every accepted response counts, a repeated one shows in the totals
				rspAccepted++;
				if (expQueue.size() != 0)
					checkValue("rsp.rd", rsp.rd, expQueue.pop_front());
			end
			else if (rsp.valid)
			begin
				holdPending = 1'b1;
				heldRd = rsp.rd;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		UsiPkg::usiCmdT lastCmd;
		void'($urandom(lpSeed));
		sysClk = 1'b0;
		rstN = 1'b0;
		cmd = '0;
		cmdReq = 1'b0;
		rspReady = 1'b0;
		draining = 1'b0;
		holdPending = 1'b0;
		heldRd = '0;
		prevAck = 1'b0;
		reqAtEdge = 1'b0;
		cycleCount = 0;
		readsIssued = 0;
		rspAccepted = 0;
		ledModel = '0;
		scratchModel = '0;
		for (int i = 0; i < 16; i++)
			ramModel[i] = '0;

		repeat (4) @(posedge sysClk);
		@(negedge sysClk);
		checkValue("cmdAck after reset", 32'(cmdAck), 32'd0);
		checkValue("rsp.valid after reset", 32'(rsp.valid), 32'd0);
		checkValue("led pins after reset", 32'({ledB, ledG, ledR, led}), 32'd0);
		rstN = 1'b1;

		for (int n = 0; n < lpNumCmds; n++)
		begin
			sendCmd(randomCmd());
			repeat ($urandom % 3) @(negedge sysClk);
		end

		// LED read last, its response means every write has landed
		lastCmd.op = UsiPkg::opRead;
		lastCmd.adrs = {12'h000, UsiPkg::lpGpioAdrsMap, 16'h0000};
		lastCmd.wd = '0;
		sendCmd(lastCmd);
		draining = 1'b1;
		while (expQueue.size() != 0 || rsp.valid)
			@(negedge sysClk);

		// Idle window with the reader ready, a stray response would be counted here
		repeat (4) @(negedge sysClk);
		@(posedge sysClk);

		checkValue("accepted response count", rspAccepted, readsIssued);
		checkValue("led pins", 32'({ledB, ledG, ledR, led}), 32'(ledModel));
		$display("TEST PASS");
		$finish;
	end

endmodule

/* logic/UsiSystem.sv */
// Top level with the command receiver, command buffer and register bus
`timescale 1ns/1ps

module UsiSystem (
	input logic sysClk,
	input logic rstN,
	// Command port
	input UsiPkg::usiCmdT cmd,
	input logic cmdReq,
	output logic cmdAck,
	// Response port
	output UsiPkg::usiRspT rsp,
	input logic rspReady,
	// LED pins
	output logic [1:0] led,
	output logic ledB,
	output logic ledG,
	output logic ledR
);

	// Receiver to buffer
	logic push;
	UsiPkg::usiCmdT pushCmd;
	logic full;

	// Buffer to bus
	logic pop;
	logic empty;
	UsiPkg::usiCmdT headCmd;

	UsiCmdReceiver cmdReceiver (
		.sysClk  (sysClk),
		.rstN    (rstN),
		.cmd     (cmd),
		.cmdReq  (cmdReq),
		.cmdAck  (cmdAck),
		.full    (full),
		.push    (push),
		.pushCmd (pushCmd)
	);

	UsiCmdFifo cmdFifo (
		.sysClk  (sysClk),
		.rstN    (rstN),
		.push    (push),
		.pushCmd (pushCmd),
		.full    (full),
		.pop     (pop),
		.empty   (empty),
		.headCmd (headCmd)
	);

	UsiBus usiBus (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.empty    (empty),
		.headCmd  (headCmd),
		.pop      (pop),
		.rspReady (rspReady),
		.rsp      (rsp),
		.led      (led),
		.ledB     (ledB),
		.ledG     (ledG),
		.ledR     (ledR)
	);

endmodule

/* logic/UsiBus.sv */
// Register bus that pops commands, decodes the block field and holds read responses
`timescale 1ns/1ps

module UsiBus (
	input logic sysClk,
	input logic rstN,
	input logic empty,
	input UsiPkg::usiCmdT headCmd,
	output logic pop,
	input logic rspReady,
	output UsiPkg::usiRspT rsp,
	output logic [1:0] led,
	output logic ledB,
	output logic ledG,
	output logic ledR
);

	logic [UsiPkg::lpBlockAdrsMap-1:0] blockAdrs;
	UsiPkg::usiSlaveReqT slaveReq;
	logic gpioSel;
	logic ramSel;
	logic [UsiPkg::lpUsiBusWidth-1:0] gpioRd;
	logic [UsiPkg::lpUsiBusWidth-1:0] ramRd;
	logic [UsiPkg::lpUsiBusWidth-1:0] busRd;
	logic rspValid;
	logic [UsiPkg::lpUsiBusWidth-1:0] rspRd;
	logic isRead;

	// ------------------------------------------------------------------------
	// Dispatch
	// A pending response that is being accepted frees the slot this cycle
	// ------------------------------------------------------------------------
	assign pop = !empty && (!rspValid || rspReady);
	assign isRead = (headCmd.op == UsiPkg::opRead);

	assign blockAdrs = headCmd.adrs[UsiPkg::lpCsrAdrsWidth +: UsiPkg::lpBlockAdrsMap];
	assign gpioSel = pop && (blockAdrs == UsiPkg::lpGpioAdrsMap);
	assign ramSel = pop && (blockAdrs == UsiPkg::lpRamAdrsMap);

	always_comb
	begin
		slaveReq.we = (headCmd.op == UsiPkg::opWrite);
		slaveReq.csrAdrs = headCmd.adrs[UsiPkg::lpCsrAdrsWidth-1:0];
		slaveReq.wd = headCmd.wd;
	end

	// Unmapped blocks read zero
	assign busRd = gpioSel ? gpioRd : (ramSel ? ramRd : '0);

	// ------------------------------------------------------------------------
	// Read response
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			rspValid <= 1'b0;
		end
		else if (pop)
		begin
			rspValid <= isRead;
		end
		else if (rspReady)
		begin
			rspValid <= 1'b0;
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (pop && isRead)
		begin
			rspRd <= busRd;
		end
	end

	assign rsp = '{valid: rspValid, rd: rspRd};

	// ------------------------------------------------------------------------
	// Slaves
	// ------------------------------------------------------------------------
	GpioBlock gpioBlock (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.slaveReq (slaveReq),
		.gpioSel  (gpioSel),
		.rd       (gpioRd),
		.led      (led),
		.ledB     (ledB),
		.ledG     (ledG),
		.ledR     (ledR)
	);

	RamBlock ramBlock (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.slaveReq (slaveReq),
		.ramSel   (ramSel),
		.rd       (ramRd)
	);

endmodule

/* logic/RamBlock.sv */
// RAM slave holding sixteen 32-bit control words
`timescale 1ns/1ps

module RamBlock (
	input logic sysClk,
	input logic rstN,
	input UsiPkg::usiSlaveReqT slaveReq,
	input logic ramSel,
	output logic [UsiPkg::lpUsiBusWidth-1:0] rd
);

	logic [UsiPkg::lpUsiBusWidth-1:0] mem [UsiPkg::lpRamWords];
	logic [UsiPkg::lpRamIdxWidth-1:0] wordIdx;

	// Word index from CSR bits 5..2
	assign wordIdx = slaveReq.csrAdrs[UsiPkg::lpRamIdxWidth+1:2];

	// ------------------------------------------------------------------------
	// Word storage, cleared as a whole on reset
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < UsiPkg::lpRamWords; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (ramSel && slaveReq.we)
		begin
			mem[wordIdx] <= slaveReq.wd;
		end
	end

	assign rd = mem[wordIdx];

endmodule

/* logic/GpioBlock.sv */
// GPIO slave with the LED and scratch CSRs driving the LED pins
`timescale 1ns/1ps

module GpioBlock (
	input logic sysClk,
	input logic rstN,
	input UsiPkg::usiSlaveReqT slaveReq,
	input logic gpioSel,
	output logic [UsiPkg::lpUsiBusWidth-1:0] rd,
	output logic [1:0] led,
	output logic ledB,
	output logic ledG,
	output logic ledR
);

	logic [UsiPkg::lpGpioCsrActiveWidth-1:0] csrAdrs;
	logic [UsiPkg::lpLedWidth-1:0] ledReg;
	logic [UsiPkg::lpUsiBusWidth-1:0] scratch;

	assign csrAdrs = slaveReq.csrAdrs[UsiPkg::lpGpioCsrActiveWidth-1:0];

	// CSR writes
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ledReg <= '0;
			scratch <= '0;
		end
		else if (gpioSel && slaveReq.we)
		begin
			case (csrAdrs)
				UsiPkg::lpGpioLedCsr: ledReg <= slaveReq.wd[UsiPkg::lpLedWidth-1:0];
				UsiPkg::lpGpioScratchCsr: scratch <= slaveReq.wd;
				default: ;
			endcase
		end
	end

	// Readback, unused CSRs return zero
	always_comb
	begin
		case (csrAdrs)
			UsiPkg::lpGpioLedCsr: rd = UsiPkg::lpUsiBusWidth'(ledReg);
			UsiPkg::lpGpioScratchCsr: rd = scratch;
			default: rd = '0;
		endcase
	end

	// LED layout: bits 1..0 plain LEDs, bit 4 blue, bit 3 green, bit 2 red
	assign led = ledReg[1:0];
	assign ledB = ledReg[4];
	assign ledG = ledReg[3];
	assign ledR = ledReg[2];

endmodule

/* logic/UsiCmdFifo.sv */
// Four-entry show-ahead command buffer with full and empty status
`timescale 1ns/1ps

module UsiCmdFifo (
	input logic sysClk,
	input logic rstN,
	input logic push,
	input UsiPkg::usiCmdT pushCmd,
	output logic full,
	input logic pop,
	output logic empty,
	output UsiPkg::usiCmdT headCmd
);

	UsiPkg::usiCmdT mem [UsiPkg::lpFifoDepth];

	logic [UsiPkg::lpFifoPtrWidth-1:0] wrPtr;
	logic [UsiPkg::lpFifoPtrWidth-1:0] rdPtr;
	logic [UsiPkg::lpFifoCntWidth-1:0] count;

	logic pushEn;
	logic popEn;

	assign pushEn = push && !full;
	assign popEn = pop && !empty;

	// ------------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (pushEn)
		begin
			mem[wrPtr] <= pushCmd;
		end
	end

	// ------------------------------------------------------------------------
	// Pointers and fill level
	// Depth is a power of two so pointers wrap on their own
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (pushEn)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (popEn)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({pushEn, popEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full = (count == UsiPkg::lpFifoCntWidth'(UsiPkg::lpFifoDepth));
	assign empty = (count == '0);

	// Show-ahead head entry
	assign headCmd = mem[rdPtr];

endmodule

/* logic/UsiCmdReceiver.sv */
// Four-phase req/ack command port feeding the command buffer
`timescale 1ns/1ps

module UsiCmdReceiver (
	input logic sysClk,
	input logic rstN,
	input UsiPkg::usiCmdT cmd,
	input logic cmdReq,
	output logic cmdAck,
	input logic full,
	output logic push,
	output UsiPkg::usiCmdT pushCmd
);

	typedef enum logic {
		rxIdle,
		rxAcked
	} rxStateT;

	rxStateT state;

	// ------------------------------------------------------------------------
	// Handshake phase
	// Idle waits for a request and a free slot, acked waits for req to drop
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			state <= rxIdle;
		end
		else
		begin
			case (state)
				rxIdle:
				begin
					if (push)
					begin
						state <= rxAcked;
					end
				end
				rxAcked:
				begin
					if (!cmdReq)
					begin
						state <= rxIdle;
					end
				end
				default:
				begin
					state <= rxIdle;
				end
			endcase
		end
	end

	// One push per request, on the same edge that raises ack
	assign push = (state == rxIdle) && cmdReq && !full;
	assign pushCmd = cmd;

	assign cmdAck = (state == rxAcked);

endmodule

/* logic/UsiPkg.sv */
// Bus widths, address map, command opcode enum and the command, response and slave structs
package UsiPkg;

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------
	localparam int lpUsiBusWidth = 32;
	localparam int lpBusAdrsBit = 32;

	// ------------------------------------------------------------------------
	// Address map
	// Block field sits right above the CSR field (bits 19..16)
	// ------------------------------------------------------------------------
	localparam int lpBlockAdrsMap = 4;
	localparam int lpCsrAdrsWidth = 16;

	localparam logic [lpBlockAdrsMap-1:0] lpGpioAdrsMap = 4'h1;
	localparam logic [lpBlockAdrsMap-1:0] lpRamAdrsMap = 4'h6;

	// GPIO decodes only the low CSR byte
	localparam int lpGpioCsrActiveWidth = 8;
	localparam logic [lpGpioCsrActiveWidth-1:0] lpGpioLedCsr = 8'h00;
	localparam logic [lpGpioCsrActiveWidth-1:0] lpGpioScratchCsr = 8'h04;
	localparam int lpLedWidth = 5;

	// RAM words are word addressed, CSR bits 5..2
	localparam int lpRamWords = 16;
	localparam int lpRamIdxWidth = $clog2(lpRamWords);

	// Command buffer
	localparam int lpFifoDepth = 4;
	localparam int lpFifoPtrWidth = $clog2(lpFifoDepth);
	localparam int lpFifoCntWidth = $clog2(lpFifoDepth + 1);

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------
	typedef enum logic {
		opWrite = 1'b0,
		opRead  = 1'b1
	} usiOpT;

	// Command from the outside master, 65 bits
	typedef struct packed {
		usiOpT op;
		logic [lpBusAdrsBit-1:0] adrs;
		logic [lpUsiBusWidth-1:0] wd;
	} usiCmdT;

	typedef struct packed {
		logic valid;
		logic [lpUsiBusWidth-1:0] rd;
	} usiRspT;

	// Broadcast to every slave
	typedef struct packed {
		logic we;
		logic [lpCsrAdrsWidth-1:0] csrAdrs;
		logic [lpUsiBusWidth-1:0] wd;
	} usiSlaveReqT;

endpackage
